// ==== verilog/cpu8_params.svh ====
// architectural widths of the cpu8 core; the modules are written for these values only
`ifndef CPU8_PARAMS_SVH
`define CPU8_PARAMS_SVH

// data path and register width
`define CPU8_DATA_W 8

// program memory addressing
`define CPU8_ADDR_W 4
`define CPU8_MEM_DEPTH 16

// opcode and operand fields of one instruction byte
`define CPU8_NIB_W 4

`endif

// ==== verilog/cpu8_pkg.sv ====
// shared cpu8 types; opcode codes 12 to 15 are not listed and decode to OP_NOP
package cpu8_pkg;

  `include "cpu8_params.svh"

  typedef logic [`CPU8_DATA_W-1:0] data_t;
  typedef logic [`CPU8_ADDR_W-1:0] addr_t;

  // upper nibble of an instruction byte
  typedef enum logic [`CPU8_NIB_W-1:0] {
    OP_NOP    = 4'd0,
    OP_LDA_LO = 4'd1,
    OP_LDA_HI = 4'd2,
    OP_LDB_LO = 4'd3,
    OP_LDB_HI = 4'd4,
    OP_LDC_LO = 4'd5,
    OP_LDC_HI = 4'd6,
    OP_ADD    = 4'd7,
    OP_SUB    = 4'd8,
    OP_MUL    = 4'd9,
    OP_OUT    = 4'd10,
    OP_IN     = 4'd11
  } opcode_t;

  // register named by the operand of IN and OUT
  typedef enum logic [1:0] {
    REG_A    = 2'd0,
    REG_B    = 2'd1,
    REG_C    = 2'd2,
    REG_NONE = 2'd3
  } reg_sel_t;

  typedef enum logic [1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_MUL
  } alu_op_t;

endpackage

// ==== verilog/alu_if.sv ====
// register file to ALU link; no handshake, result is combinational in the same cycle
`timescale 1ns/1ps

interface alu_if;
  import cpu8_pkg::*;

  data_t   a;
  data_t   b;
  alu_op_t op;
  data_t   result;

  // register file side
  modport regs (output a, output b, output op, input result);

  // arithmetic side
  modport alu (input a, input b, input op, output result);

endinterface

// ==== verilog/program_memory.sv ====
// 16 x 8 program store; one write per clock, asynchronous read, whole array cleared by reset
`timescale 1ns/1ps

module program_memory (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            wr_en,
  input  cpu8_pkg::addr_t wr_addr,
  input  cpu8_pkg::data_t wr_data,
  input  cpu8_pkg::addr_t rd_addr,
  output cpu8_pkg::data_t rd_data
);
  import cpu8_pkg::*;

  `include "cpu8_params.svh"

  data_t mem [`CPU8_MEM_DEPTH];

  ////////////////////////////////////////
  // host write port
  ////////////////////////////////////////

  // a program of all zero bytes is all NOPs
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem <= '{default: '0};
    end else if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  ////////////////////////////////////////
  // fetch read port
  ////////////////////////////////////////

  // written byte shows here from the cycle after the write edge
  assign rd_data = mem[rd_addr];

endmodule

// ==== verilog/fetch_decode.sv ====
// program counter and decoder; pc wraps at 16 and only moves while run is high
`timescale 1ns/1ps

`include "cpu8_params.svh"

module fetch_decode (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              run,
  input  cpu8_pkg::data_t   instr,
  output cpu8_pkg::addr_t   pc,
  output logic              exec,
  output cpu8_pkg::opcode_t opcode,
  output logic [`CPU8_NIB_W-1:0] operand
);
  import cpu8_pkg::*;

  logic [`CPU8_NIB_W-1:0] op_field;

  ////////////////////////////////////////
  // program counter
  ////////////////////////////////////////

  // natural 4-bit overflow gives the wrap after address 15
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (run) begin
      pc <= pc + 1'b1;
    end
  end

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////

  assign op_field = instr[`CPU8_DATA_W-1:`CPU8_NIB_W];
  assign operand  = instr[`CPU8_NIB_W-1:0];

  always_comb begin
    case (op_field)
      4'd1:    opcode = OP_LDA_LO;
      4'd2:    opcode = OP_LDA_HI;
      4'd3:    opcode = OP_LDB_LO;
      4'd4:    opcode = OP_LDB_HI;
      4'd5:    opcode = OP_LDC_LO;
      4'd6:    opcode = OP_LDC_HI;
      4'd7:    opcode = OP_ADD;
      4'd8:    opcode = OP_SUB;
      4'd9:    opcode = OP_MUL;
      4'd10:   opcode = OP_OUT;
      4'd11:   opcode = OP_IN;
      // 0 and the unused codes 12..15
      default: opcode = OP_NOP;
    endcase
  end

  // the fetched instruction executes on every edge where run is high
  assign exec = run;

endmodule

// ==== verilog/alu.sv ====
// modulo-256 add, subtract and multiply of A and B; purely combinational, no flags
`timescale 1ns/1ps

module alu (
  alu_if.alu alu_port
);
  import cpu8_pkg::*;

  `include "cpu8_params.svh"

  logic [2*`CPU8_DATA_W-1:0] product;
  data_t                     diff;

  // full product, only the low byte is kept
  assign product = alu_port.a * alu_port.b;

  // two's-complement difference, borrow dropped
  assign diff = alu_port.a + (~alu_port.b) + 1'b1;

  always_comb begin
    case (alu_port.op)
      ALU_SUB: alu_port.result = diff;
      ALU_MUL: alu_port.result = product[`CPU8_DATA_W-1:0];
      default: alu_port.result = alu_port.a + alu_port.b;
    endcase
  end

endmodule

// ==== verilog/register_file.sv ====
// registers A, B, C and the output latch; all change only on edges where exec is high
`timescale 1ns/1ps

`include "cpu8_params.svh"

module register_file (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              exec,
  input  cpu8_pkg::opcode_t opcode,
  input  logic [`CPU8_NIB_W-1:0] operand,
  input  cpu8_pkg::data_t   in_data,
  output cpu8_pkg::data_t   out_data,
  alu_if.regs               alu_port
);
  import cpu8_pkg::*;

  data_t    reg_a;
  data_t    reg_b;
  data_t    reg_c;
  data_t    out_q;
  reg_sel_t sel;

  ////////////////////////////////////////
  // operand and ALU control
  ////////////////////////////////////////

  // only operands 0..2 name a register
  always_comb begin
    case (operand)
      4'd0:    sel = REG_A;
      4'd1:    sel = REG_B;
      4'd2:    sel = REG_C;
      default: sel = REG_NONE;
    endcase
  end

  always_comb begin
    case (opcode)
      OP_SUB:  alu_port.op = ALU_SUB;
      OP_MUL:  alu_port.op = ALU_MUL;
      default: alu_port.op = ALU_ADD;
    endcase
  end

  assign alu_port.a = reg_a;
  assign alu_port.b = reg_b;

  ////////////////////////////////////////
  // register update
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reg_a <= '0;
      reg_b <= '0;
      reg_c <= '0;
      out_q <= '0;
    end else if (exec) begin
      case (opcode)
        // nibble loads keep the other half
        OP_LDA_LO: reg_a <= {reg_a[`CPU8_DATA_W-1:`CPU8_NIB_W], operand};
        OP_LDA_HI: reg_a <= {operand, reg_a[`CPU8_NIB_W-1:0]};
        OP_LDB_LO: reg_b <= {reg_b[`CPU8_DATA_W-1:`CPU8_NIB_W], operand};
        OP_LDB_HI: reg_b <= {operand, reg_b[`CPU8_NIB_W-1:0]};
        OP_LDC_LO: reg_c <= {reg_c[`CPU8_DATA_W-1:`CPU8_NIB_W], operand};
        OP_LDC_HI: reg_c <= {operand, reg_c[`CPU8_NIB_W-1:0]};
        OP_ADD, OP_SUB, OP_MUL: begin
          reg_c <= alu_port.result;
        end
        OP_IN: begin
          case (sel)
            REG_A:   reg_a <= in_data;
            REG_B:   reg_b <= in_data;
            REG_C:   reg_c <= in_data;
            default: ;
          endcase
        end
        OP_OUT: begin
          case (sel)
            REG_A:   out_q <= reg_a;
            REG_B:   out_q <= reg_b;
            REG_C:   out_q <= reg_c;
            default: ;
          endcase
        end
        default: ;
      endcase
    end
  end

  assign out_data = out_q;

endmodule

// ==== verilog/cpu8_top.sv ====
// cpu8 top; uio_in[7] is run, [4] the load strobe, [3:0] the load address, [6:5] are unused
`timescale 1ns/1ps

module cpu8_top (
  input  logic            clk,
  input  logic            rst_n,
  input  cpu8_pkg::data_t ui_in,
  input  logic [7:0]      uio_in,
  output cpu8_pkg::data_t uo_out
);
  import cpu8_pkg::*;

  `include "cpu8_params.svh"

  logic                   run;
  logic                   strobe;
  addr_t                  load_addr;
  addr_t                  pc;
  data_t                  instr;
  logic                   exec;
  opcode_t                opcode;
  logic [`CPU8_NIB_W-1:0] operand;

  alu_if alu_bus ();

  ////////////////////////////////////////
  // control pins
  ////////////////////////////////////////

  assign run       = uio_in[7];
  assign strobe    = uio_in[4];
  assign load_addr = uio_in[`CPU8_ADDR_W-1:0];

  ////////////////////////////////////////
  // core
  ////////////////////////////////////////

  // host writes are locked out while the program runs
  program_memory i_program_memory (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (strobe & ~run),
    .wr_addr (load_addr),
    .wr_data (ui_in),
    .rd_addr (pc),
    .rd_data (instr)
  );

  fetch_decode i_fetch_decode (
    .clk     (clk),
    .rst_n   (rst_n),
    .run     (run),
    .instr   (instr),
    .pc      (pc),
    .exec    (exec),
    .opcode  (opcode),
    .operand (operand)
  );

  // ui_in doubles as IN data once loading is done
  register_file i_register_file (
    .clk      (clk),
    .rst_n    (rst_n),
    .exec     (exec),
    .opcode   (opcode),
    .operand  (operand),
    .in_data  (ui_in),
    .out_data (uo_out),
    .alu_port (alu_bus.regs)
  );

  alu i_alu (
    .alu_port (alu_bus.alu)
  );

endmodule

// ==== tests/tb_tasks.svh ====
// testbench helpers; the including module must declare clk, rst_n, ui_in, uio_in, uo_out, program_buf
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

int          error_count = 0;
logic [31:0] lcg_state   = 32'hdb8b_791d;

////////////////////////////////////////
// checking
////////////////////////////////////////

task automatic check(
  input logic [31:0] actual,
  input logic [31:0] expected,
  input string       what
);
  if (actual !== expected) begin
    error_count++;
    $display("Fail at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
    $display("Test failures found");
    $fatal(1, "stopped at the first mismatch");
  end
endtask

////////////////////////////////////////
// stimulus values
////////////////////////////////////////

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// upper bits of the LCG have the longest period
function automatic logic [7:0] rand_byte();
  logic [31:0] r;
  r = lcg_next();
  return r[23:16];
endfunction

function automatic logic [3:0] rand_nibble();
  logic [31:0] r;
  r = lcg_next();
  return r[27:24];
endfunction

// instruction byte: opcode in the upper nibble, operand in the lower
function automatic logic [7:0] encode(input opcode_t op, input logic [3:0] arg);
  return {op, arg};
endfunction

////////////////////////////////////////
// sequencing
////////////////////////////////////////

// every drive happens 1 ns after a rising edge
task automatic next_cycle();
  @(posedge clk);
  #1;
endtask

task automatic apply_reset();
  rst_n  = 1'b0;
  uio_in = '0;
  ui_in  = '0;
  repeat (3) next_cycle();
  rst_n = 1'b1;
endtask

task automatic clear_program();
  foreach (program_buf[i]) begin
    program_buf[i] = encode(OP_NOP, 4'h0);
  end
endtask

// one strobed byte per clock with run low
task automatic load_program();
  for (int i = 0; i < 16; i++) begin
    ui_in  = program_buf[i];
    uio_in = {1'b0, 2'b00, 1'b1, i[3:0]};
    next_cycle();
  end
  uio_in = '0;
  ui_in  = '0;
endtask

// exactly n executing edges, then run goes low again
task automatic run_cycles(input int n);
  uio_in = 8'h80;
  repeat (n) next_cycle();
  uio_in = '0;
endtask

task automatic run_until_out(input logic [7:0] expected, input int max_cycles);
  int count;
  count  = 0;
  uio_in = 8'h80;
  next_cycle();
  while (uo_out !== expected && count < max_cycles) begin
    next_cycle();
    count++;
  end
  uio_in = '0;
  if (uo_out !== expected) begin
    error_count++;
    $display("Error at %0t ns: output never reached the expected value %0h", $time, expected);
    $display("Test failures found");
    $fatal(1, "timed out waiting on uo_out");
  end
endtask

`endif

// ==== tests/tb_cpu8.sv ====
// directed testbench for cpu8_top; stops at the first failure, stimulus from a fixed-seed LCG
`timescale 1ns/1ps

module tb_cpu8;
  import cpu8_pkg::*;

  logic       clk;
  logic       rst_n;
  logic [7:0] ui_in;
  logic [7:0] uio_in;
  logic [7:0] uo_out;
  logic [7:0] program_buf [16];

  `include "tb_tasks.svh"

  cpu8_top i_dut (
    .clk    (clk),
    .rst_n  (rst_n),
    .ui_in  (ui_in),
    .uio_in (uio_in),
    .uo_out (uo_out)
  );

  // 8 ns clock
  initial clk = 1'b0;
  always #4 clk = ~clk;

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic reset_and_idle();
    apply_reset();
    check(uo_out, 8'h00, "uo_out after reset");
    clear_program();
    load_program();
    // live input data must not leak to the output through NOPs
    ui_in = rand_byte() | 8'h01;
    for (int i = 0; i < 20; i++) begin
      run_cycles(1);
      check(uo_out, 8'h00, "uo_out while running NOPs");
    end
    ui_in = '0;
  endtask

  task automatic nibble_loads();
    logic [3:0] a_lo;
    logic [3:0] a_hi;
    logic [3:0] b_lo;
    logic [3:0] b_hi;
    logic [3:0] c_lo;
    logic [3:0] c_hi;
    logic [3:0] a_new;
    for (int round = 0; round < 4; round++) begin
      a_lo  = rand_nibble();
      a_hi  = rand_nibble();
      b_lo  = rand_nibble();
      b_hi  = rand_nibble();
      c_lo  = rand_nibble();
      c_hi  = rand_nibble();
      a_new = rand_nibble();
      apply_reset();
      clear_program();
      program_buf[0]  = encode(OP_LDA_LO, a_lo);
      program_buf[1]  = encode(OP_LDA_HI, a_hi);
      program_buf[2]  = encode(OP_LDB_LO, b_lo);
      program_buf[3]  = encode(OP_LDB_HI, b_hi);
      program_buf[4]  = encode(OP_LDC_LO, c_lo);
      program_buf[5]  = encode(OP_LDC_HI, c_hi);
      program_buf[6]  = encode(OP_OUT, 4'd0);
      program_buf[7]  = encode(OP_OUT, 4'd1);
      program_buf[8]  = encode(OP_OUT, 4'd2);
      program_buf[9]  = encode(OP_LDA_LO, a_new);
      program_buf[10] = encode(OP_OUT, 4'd0);
      load_program();
      run_cycles(7);
      check(uo_out, {a_hi, a_lo}, "OUT A after nibble loads");
      run_cycles(1);
      check(uo_out, {b_hi, b_lo}, "OUT B after nibble loads");
      run_cycles(1);
      check(uo_out, {c_hi, c_lo}, "OUT C after nibble loads");
      // a second low load must leave the high half alone
      run_cycles(2);
      check(uo_out, {a_hi, a_new}, "OUT A after low nibble reload");
    end
  endtask

  task automatic arithmetic_ops();
    logic [7:0] a_val;
    logic [7:0] b_val;
    logic [7:0] exp_sum;
    logic [7:0] exp_diff;
    logic [7:0] exp_prod;
    for (int pair = 0; pair < 6; pair++) begin
      a_val    = rand_byte();
      b_val    = rand_byte();
      exp_sum  = a_val + b_val;
      exp_diff = a_val - b_val;
      exp_prod = a_val * b_val;
      apply_reset();
      clear_program();
      program_buf[0] = encode(OP_LDA_LO, a_val[3:0]);
      program_buf[1] = encode(OP_LDA_HI, a_val[7:4]);
      program_buf[2] = encode(OP_LDB_LO, b_val[3:0]);
      program_buf[3] = encode(OP_LDB_HI, b_val[7:4]);
      program_buf[4] = encode(OP_ADD, 4'd0);
      program_buf[5] = encode(OP_OUT, 4'd2);
      program_buf[6] = encode(OP_SUB, 4'd0);
      program_buf[7] = encode(OP_OUT, 4'd2);
      program_buf[8] = encode(OP_MUL, 4'd0);
      program_buf[9] = encode(OP_OUT, 4'd2);
      load_program();
      run_cycles(6);
      check(uo_out, exp_sum, "ADD result in C");
      run_cycles(2);
      check(uo_out, exp_diff, "SUB result in C");
      run_cycles(2);
      check(uo_out, exp_prod, "MUL result in C");
    end
  endtask

  task automatic input_capture();
    logic [7:0] in_val;
    logic [3:0] other;
    for (int r = 0; r < 3; r++) begin
      in_val = rand_byte() | 8'h01;
      other  = (r + 1) % 3;
      apply_reset();
      clear_program();
      // operand 3 names no register and must not write anything
      program_buf[0] = encode(OP_IN, 4'd3);
      program_buf[1] = encode(OP_IN, r[3:0]);
      program_buf[2] = encode(OP_OUT, r[3:0]);
      program_buf[3] = encode(OP_OUT, other);
      load_program();
      ui_in = in_val;
      run_until_out(in_val, 10);
      run_cycles(1);
      check(uo_out, 8'h00, "IN wrote a register it did not select");
      ui_in = '0;
    end
  endtask

  task automatic pause_and_wrap();
    logic [7:0] a_val;
    logic [7:0] b_val;
    logic [7:0] w_val;
    a_val = rand_byte() | 8'h01;
    b_val = ~a_val;
    apply_reset();
    clear_program();
    program_buf[0] = encode(OP_LDA_LO, a_val[3:0]);
    program_buf[1] = encode(OP_LDA_HI, a_val[7:4]);
    program_buf[2] = encode(OP_OUT, 4'd0);
    program_buf[3] = encode(OP_LDB_LO, b_val[3:0]);
    program_buf[4] = encode(OP_LDB_HI, b_val[7:4]);
    program_buf[5] = encode(OP_OUT, 4'd1);
    load_program();
    run_cycles(3);
    check(uo_out, a_val, "first OUT before the pause");
    repeat (5) begin
      next_cycle();
      check(uo_out, a_val, "uo_out held while run is low");
    end
    run_cycles(3);
    check(uo_out, b_val, "second OUT after the pause");

    // only OUT sits at address 0, A changes right after it
    w_val = rand_byte() | 8'h80;
    apply_reset();
    clear_program();
    program_buf[0] = encode(OP_OUT, 4'd0);
    program_buf[1] = encode(OP_LDA_LO, w_val[3:0]);
    program_buf[2] = encode(OP_LDA_HI, w_val[7:4]);
    load_program();
    run_cycles(16);
    check(uo_out, 8'h00, "uo_out before the counter wraps");
    run_cycles(1);
    check(uo_out, w_val, "OUT A at address 0 after the wrap");

    // pc is 1 here; try to replace address 0 with OUT B while running
    ui_in  = encode(OP_OUT, 4'd1);
    uio_in = {1'b1, 2'b00, 1'b1, 4'h0};
    repeat (16) next_cycle();
    uio_in = '0;
    ui_in  = '0;
    check(uo_out, w_val, "strobe while running changed the program");
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    rst_n  = 1'b0;
    ui_in  = '0;
    uio_in = '0;
    clear_program();
    reset_and_idle();
    nibble_loads();
    arithmetic_ops();
    input_capture();
    pause_and_wrap();
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== cpu8.f ====
+incdir+verilog
+incdir+tests
verilog/cpu8_pkg.sv
verilog/alu_if.sv
verilog/program_memory.sv
verilog/fetch_decode.sv
verilog/alu.sv
verilog/register_file.sv
verilog/cpu8_top.sv
tests/tb_cpu8.sv
